// ==== bench/icache_assertions.sv ====
`default_nettype none

module icache_assertions
  (input wire   clk_i
   , input wire reset_i
   , input wire data_v_i
   , input wire miss_v_i
   , input wire ready_i
   , input wire miss_req_v_i
   , input wire refill_v_i
   );

  // At most one result per fetch
  result_exclusive: assert property
    (@(posedge clk_i) disable iff (reset_i) !(data_v_i && miss_v_i))
    else $error("data_v_o and miss_v_o high in the same cycle");

  // No new fetch while a refill is outstanding
  ready_blocked: assert property
    (@(posedge clk_i) disable iff (reset_i) miss_req_v_i |-> !ready_i)
    else $error("ready_o high while miss_req_v_o is up");

  // Request level holds until its refill
  request_held: assert property
    (@(posedge clk_i) disable iff (reset_i) miss_req_v_i && !refill_v_i |=> miss_req_v_i)
    else $error("miss_req_v_o dropped before refill_v_i");

endmodule

`default_nettype wire

// ==== bench/icache_tb.sv ====
`default_nettype none

module icache_tb;

  typedef enum logic [1:0] {out_hit, out_miss, out_drop} outcome_e;

  typedef struct packed {
    logic [31:0] vaddr;
    logic        ptag_v;
    outcome_e    outcome;
  } row_s;

  typedef struct packed {
    int row;
    int due;
  } inflight_s;

  localparam int rows_c           = 21;
  localparam int timeout_cycles_c = rows_c * 12 + 50;

  localparam row_s stim_c [rows_c] = '{
    // Cold block, refetch, then all four words back to back
    '{32'h0001_2340, 1'b1, out_miss},
    '{32'h0001_2344, 1'b1, out_drop},
    '{32'h0001_2340, 1'b1, out_hit},
    '{32'h0001_2344, 1'b1, out_hit},
    '{32'h0001_2348, 1'b1, out_hit},
    '{32'h0001_234C, 1'b1, out_hit},
    // Physical tag withheld
    '{32'h0001_2348, 1'b0, out_drop},
    '{32'h0001_234C, 1'b1, out_hit},
    // Tags A, B and C all in set 0x10
    '{32'h0AAA_A100, 1'b1, out_miss},
    '{32'h0AAA_A104, 1'b1, out_drop},
    '{32'h0BBB_B104, 1'b1, out_miss},
    '{32'h0BBB_B108, 1'b1, out_drop},
    '{32'h0AAA_A108, 1'b1, out_hit},
    '{32'h0CCC_C10C, 1'b1, out_miss},
    '{32'h0CCC_C100, 1'b1, out_drop},
    '{32'h0AAA_A10C, 1'b1, out_hit},
    '{32'h0BBB_B100, 1'b1, out_miss},
    '{32'h0BBB_B104, 1'b1, out_drop},
    '{32'h0BBB_B104, 1'b1, out_hit},
    '{32'h0AAA_A100, 1'b1, out_hit},
    '{32'h0001_2340, 1'b1, out_hit}
  };

  logic                                 clk_i = 1'b0;
  logic                                 reset_i;
  logic                                 fetch_v_i;
  icache_pkg::fetch_req_s               fetch_req_i;
  logic                                 ready_o;
  logic                                 ptag_v_i;
  logic [icache_pkg::ptag_width_c-1:0]  ptag_i;
  logic [icache_pkg::instr_width_c-1:0] data_o;
  logic                                 data_v_o;
  logic                                 miss_v_o;
  logic                                 miss_req_v_o;
  logic [icache_pkg::addr_width_c-1:0]  miss_req_addr_o;
  logic                                 refill_v_i;
  icache_pkg::block_t                   refill_block_i;

  inflight_s   inflight [$];
  int          cycle_count;
  logic        miss_seen;
  logic [31:0] req_addr_exp;
  logic        end_reported;

  always #10 clk_i = ~clk_i;

  icache_top #(.sets_p(icache_pkg::sets_c)) UUT
    (.clk_i           (clk_i)
     ,.reset_i        (reset_i)
     ,.fetch_v_i      (fetch_v_i)
     ,.fetch_req_i    (fetch_req_i)
     ,.ready_o        (ready_o)
     ,.ptag_v_i       (ptag_v_i)
     ,.ptag_i         (ptag_i)
     ,.data_o         (data_o)
     ,.data_v_o       (data_v_o)
     ,.miss_v_o       (miss_v_o)
     ,.miss_req_v_o   (miss_req_v_o)
     ,.miss_req_addr_o(miss_req_addr_o)
     ,.refill_v_i     (refill_v_i)
     ,.refill_block_i (refill_block_i)
     );

  bind icache_top icache_assertions port_rules
    (.clk_i        (clk_i)
     ,.reset_i     (reset_i)
     ,.data_v_i    (data_v_o)
     ,.miss_v_i    (miss_v_o)
     ,.ready_i     (ready_o)
     ,.miss_req_v_i(miss_req_v_o)
     ,.refill_v_i  (refill_v_i)
     );

  ////////////////////////////////////////////////////////////
  // Memory model with word k holding its address plus 4k XOR A5A5A5A5
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] block_addr(input logic [31:0] addr);
    return {addr[31:4], 4'b0000};
  endfunction

  function automatic logic [31:0] word_value(input logic [31:0] baddr, input int k);
    return (baddr + 4 * k) ^ 32'hA5A5_A5A5;
  endfunction

  function automatic icache_pkg::block_t make_block(input logic [31:0] baddr);
    icache_pkg::block_t blk;
    blk = '0;
    for (int k = 0; k < 4; k++)
      blk[k*32 +: 32] = word_value(baddr, k);
    return blk;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      end_reported = 1'b1;
      $display("Mismatch at time %0t: %s, expected %h, got %h", $time, what, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // Compares this cycle's results with the oldest fetch due now
  task automatic check_outputs();
    outcome_e    outcome;
    logic [31:0] vaddr;
    outcome = out_drop;
    vaddr   = '0;
    if (inflight.size() > 0 && inflight[0].due == cycle_count)
    begin
      outcome = stim_c[inflight[0].row].outcome;
      vaddr   = stim_c[inflight[0].row].vaddr;
      void'(inflight.pop_front());
    end
    check_value(32'(data_v_o), (outcome == out_hit) ? 32'd1 : 32'd0, "data_v_o");
    check_value(32'(miss_v_o), (outcome == out_miss) ? 32'd1 : 32'd0, "miss_v_o");
    if (outcome == out_hit)
      check_value(data_o, word_value(block_addr(vaddr), int'(vaddr[3:2])), "data_o");
    if (outcome == out_miss)
    begin
      check_value(32'(miss_req_v_o), 32'd1, "miss_req_v_o with the miss");
      req_addr_exp = block_addr(vaddr);
      miss_seen    = 1'b1;
    end
    if (!miss_seen)
      check_value(32'(miss_req_v_o), 32'd0, "miss_req_v_o before the first miss");
    // Request address stays on the missed block until the refill
    if (miss_seen && miss_req_v_o)
      check_value(miss_req_addr_o, req_addr_exp, "miss_req_addr_o");
  endtask

  ////////////////////////////////////////////////////////////
  // Refill responder
  ////////////////////////////////////////////////////////////
  initial
  begin : refill_responder
    int unsigned delay;
    logic [31:0] req_addr;
    void'($urandom(38));
    refill_v_i     = 1'b0;
    refill_block_i = '0;
    forever
    begin
      @(negedge clk_i);
      if (!reset_i && miss_req_v_o)
      begin
        req_addr = miss_req_addr_o;
        delay    = 1 + ($urandom % 6);
        repeat (delay) @(posedge clk_i);
        refill_v_i     <= 1'b1;
        refill_block_i <= make_block(req_addr);
        @(posedge clk_i);
        refill_v_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus table and result checks
  ////////////////////////////////////////////////////////////
  initial
  begin : stimulus
    int   next_row;
    logic accepted;
    reset_i      = 1'b1;
    fetch_v_i    = 1'b0;
    fetch_req_i  = '0;
    ptag_v_i     = 1'b0;
    ptag_i       = '0;
    cycle_count  = 0;
    miss_seen    = 1'b0;
    req_addr_exp = '0;
    end_reported = 1'b0;
    next_row     = 0;
    accepted     = 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value(32'(ready_o), 32'd1, "ready_o after reset");
    check_value(32'(miss_req_v_o), 32'd0, "miss_req_v_o after reset");
    while (next_row < rows_c || inflight.size() > 0)
    begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count >= timeout_cycles_c)
      begin
        end_reported = 1'b1;
        $display("Timeout: table not finished after %0d cycles", cycle_count);
        $display("Something failed");
        $fatal(1);
      end
      // Fetch taken at this edge needs its physical tag now
      if (accepted)
      begin
        ptag_v_i <= stim_c[next_row].ptag_v;
        ptag_i   <= stim_c[next_row].vaddr[31:12];
        next_row++;
      end
      else
        ptag_v_i <= 1'b0;
      if (next_row < rows_c)
      begin
        fetch_v_i         <= 1'b1;
        fetch_req_i.vaddr <= stim_c[next_row].vaddr;
      end
      else
        fetch_v_i <= 1'b0;
      @(negedge clk_i);
      check_outputs();
      accepted = fetch_v_i && ready_o;
      if (accepted)
        inflight.push_back(inflight_s'{row: next_row, due: cycle_count + 2});
    end
    check_value(32'(miss_req_v_o), 32'd0, "miss_req_v_o idle at the end");
    end_reported = 1'b1;
    $display("Everything OK");
    $finish;
  end

  // Run stopped from outside the table, such as by a failed assertion
  final
  begin
    if (!end_reported)
      $display("Something failed");
  end

endmodule

`default_nettype wire

// ==== design/icache_arrays.sv ====
`default_nettype none

module icache_arrays
  #(parameter int sets_p = 64
    )
  (input wire                                   clk_i
   , input wire                                 reset_i
   , input wire icache_pkg::array_rd_s          rd_i
   , input wire icache_pkg::array_wr_s          wr_i
   , output icache_pkg::tag_entry_s [icache_pkg::ways_c-1:0] tags_o
   , output icache_pkg::block_t [icache_pkg::ways_c-1:0]     blocks_o
   );

  logic [icache_pkg::index_width_c-1:0] addr;

  // Writes only come in the miss state when no reads go out
  assign addr = wr_i.v ? wr_i.index : rd_i.index;

  ////////////////////////////////////////////////////////////
  // One tag and one data array per way
  ////////////////////////////////////////////////////////////
  for (genvar w = 0; w < icache_pkg::ways_c; w++)
  begin : g_way
    logic way_we;
    logic way_v;

    assign way_we = wr_i.v & wr_i.way[w];
    assign way_v  = rd_i.v | way_we;

    icache_sram
      #(.entry_t (icache_pkg::tag_entry_s)
        ,.els_p  (sets_p)
        )
      tag_mem
        (.clk_i   (clk_i)
         ,.reset_i(reset_i)
         ,.v_i    (way_v)
         ,.w_i    (way_we)
         ,.addr_i (addr)
         ,.data_i (wr_i.entry)
         ,.data_o (tags_o[w])
         );

    icache_sram
      #(.entry_t (icache_pkg::block_t)
        ,.els_p  (sets_p)
        )
      data_mem
        (.clk_i   (clk_i)
         ,.reset_i(reset_i)
         ,.v_i    (way_v)
         ,.w_i    (way_we)
         ,.addr_i (addr)
         ,.data_i (wr_i.block)
         ,.data_o (blocks_o[w])
         );
  end

endmodule

`default_nettype wire

// ==== design/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int addr_width_c        = 32;
  localparam int instr_width_c       = 32;
  localparam int block_width_c       = 128;
  localparam int ways_c              = 2;
  localparam int sets_c              = 64;
  localparam int offset_width_c      = 4;
  localparam int index_width_c       = 6;
  localparam int ptag_width_c        = 20;
  // Index and offset both sit inside the page offset
  localparam int page_offset_width_c = offset_width_c + index_width_c + 2;

  ////////////////////////////////////////////////////////////
  // Payload and stage records
  ////////////////////////////////////////////////////////////
  typedef logic [block_width_c-1:0] block_t;

  typedef struct packed {
    logic                    v;
    logic [ptag_width_c-1:0] tag;
  } tag_entry_s;

  typedef struct packed {
    logic [addr_width_c-1:0] vaddr;
  } fetch_req_s;

  typedef struct packed {
    logic                     v;
    logic [index_width_c-1:0] index;
  } array_rd_s;

  typedef struct packed {
    logic                     v;
    logic [index_width_c-1:0] index;
    logic [ways_c-1:0]        way;
    tag_entry_s               entry;
    block_t                   block;
  } array_wr_s;

  typedef struct packed {
    logic                    v;
    logic [addr_width_c-1:0] paddr;
    logic [ways_c-1:0]       hit;
    logic [ways_c-1:0]       way_v;
    block_t [ways_c-1:0]     blocks;
  } tv_stage_s;

endpackage

`default_nettype wire

// ==== design/icache_sram.sv ====
`default_nettype none

module icache_sram
  #(parameter type entry_t = logic
    , parameter int els_p  = 64
    )
  (input wire                                 clk_i
   , input wire                               reset_i
   , input wire                               v_i
   , input wire                               w_i
   , input wire [icache_pkg::index_width_c-1:0] addr_i
   , input wire entry_t                       data_i
   , output entry_t                           data_o
   );

  entry_t mem_r [els_p];

  // One access per cycle and the output holds the last read
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < els_p; i++)
        mem_r[i] <= '0;
      data_o <= '0;
    end
    else if (v_i)
    begin
      if (w_i)
        mem_r[addr_i] <= data_i;
      else
        data_o <= mem_r[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_tag_lookup.sv ====
`default_nettype none

module icache_tag_lookup
  (input wire                                            clk_i
   , input wire                                          reset_i

   // Decode
   , input wire                                          fetch_v_i
   , input wire icache_pkg::fetch_req_s                  fetch_req_i
   , output logic                                        ready_o
   , output icache_pkg::array_rd_s                       rd_o

   // Tag lookup
   , input wire                                          ptag_v_i
   , input wire [icache_pkg::ptag_width_c-1:0]           ptag_i
   , input wire icache_pkg::tag_entry_s [icache_pkg::ways_c-1:0] tags_i
   , input wire icache_pkg::block_t [icache_pkg::ways_c-1:0]     blocks_i

   // Feedback from tag verify
   , input wire                                          accept_ok_i
   , input wire                                          miss_now_i

   , output icache_pkg::tv_stage_s                       tv_o
   );

  logic                                  accept;
  logic                                  tl_v_r;
  logic [icache_pkg::addr_width_c-1:0]   vaddr_tl_r;
  logic [icache_pkg::ways_c-1:0]         hit_tl;
  logic [icache_pkg::ways_c-1:0]         way_v_tl;
  logic                                  tv_we;
  logic                                  tv_v_r;
  icache_pkg::tv_stage_s                 tv_n;
  icache_pkg::tv_stage_s                 tv_r;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  assign ready_o = accept_ok_i;
  assign accept  = fetch_v_i & accept_ok_i;

  // Index read goes out in the accept cycle
  assign rd_o = '{v: accept,
                  index: fetch_req_i.vaddr[icache_pkg::offset_width_c +:
                                           icache_pkg::index_width_c]};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else
      tl_v_r <= accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      vaddr_tl_r <= fetch_req_i.vaddr;
  end

  ////////////////////////////////////////////////////////////
  // Tag lookup
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int w = 0; w < icache_pkg::ways_c; w++)
    begin
      way_v_tl[w] = tags_i[w].v;
      hit_tl[w]   = tags_i[w].v & (tags_i[w].tag == ptag_i);
    end
  end

  // Lost ptag or a miss ahead of us drops this fetch
  assign tv_we = tl_v_r & ptag_v_i & ~miss_now_i;

  assign tv_n = '{v: tv_we,
                  paddr: {ptag_i, vaddr_tl_r[icache_pkg::page_offset_width_c-1:0]},
                  hit: hit_tl,
                  way_v: way_v_tl,
                  blocks: blocks_i};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else
      tv_v_r <= tv_we;
  end

  always_ff @(posedge clk_i)
  begin
    if (tv_we)
      tv_r <= tv_n;
  end

  always_comb
  begin
    tv_o   = tv_r;
    tv_o.v = tv_v_r;
  end

endmodule

`default_nettype wire

// ==== design/icache_tag_verify.sv ====
`default_nettype none

module icache_tag_verify
  #(parameter int sets_p = 64
    )
  (input wire                                         clk_i
   , input wire                                       reset_i
   , input wire icache_pkg::tv_stage_s                tv_i

   // Fill from memory
   , input wire                                       refill_v_i
   , input wire icache_pkg::block_t                   refill_block_i
   , output icache_pkg::array_wr_s                    wr_o

   // Back to tag lookup
   , output logic                                     accept_ok_o
   , output logic                                     miss_now_o

   // Results
   , output logic [icache_pkg::instr_width_c-1:0]     data_o
   , output logic                                     data_v_o
   , output logic                                     miss_v_o
   , output logic                                     miss_req_v_o
   , output logic [icache_pkg::addr_width_c-1:0]      miss_req_addr_o
   );

  typedef enum logic {e_ready, e_miss} state_e;

  state_e                                state_r;
  state_e                                state_n;
  logic [sets_p-1:0]                     lru_r;
  logic [icache_pkg::index_width_c-1:0]  tv_index;
  logic [icache_pkg::index_width_c-1:0]  miss_index;
  logic [icache_pkg::addr_width_c-1:0]   tv_block_addr;
  logic [icache_pkg::addr_width_c-1:0]   miss_addr_r;
  logic [icache_pkg::ways_c-1:0]         miss_way_v_r;
  logic                                  hit_any;
  logic                                  hit_id;
  icache_pkg::block_t                    hit_block;
  logic [icache_pkg::ways_c-1:0]         victim_oh;
  logic                                  invalid_found;

  assign tv_index      = tv_i.paddr[icache_pkg::offset_width_c +: icache_pkg::index_width_c];
  assign miss_index    = miss_addr_r[icache_pkg::offset_width_c +: icache_pkg::index_width_c];
  assign tv_block_addr = {tv_i.paddr[icache_pkg::addr_width_c-1:icache_pkg::offset_width_c],
                          {icache_pkg::offset_width_c{1'b0}}};

  ////////////////////////////////////////////////////////////
  // Hit select and word select
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    hit_block = '0;
    hit_id    = 1'b0;
    for (int w = 0; w < icache_pkg::ways_c; w++)
    begin
      if (tv_i.hit[w])
      begin
        hit_block = hit_block | tv_i.blocks[w];
        hit_id    = 1'(w);
      end
    end
  end

  assign hit_any  = |tv_i.hit;
  assign data_o   = hit_block[tv_i.paddr[icache_pkg::offset_width_c-1:2] *
                              icache_pkg::instr_width_c +: icache_pkg::instr_width_c];
  assign data_v_o = tv_i.v & hit_any;
  assign miss_v_o = tv_i.v & ~hit_any;

  assign miss_now_o  = miss_v_o;
  assign accept_ok_o = (state_r == e_ready) & ~miss_v_o;

  ////////////////////////////////////////////////////////////
  // Miss FSM
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (state_r)
      e_ready: state_n = miss_v_o ? e_miss : e_ready;
      e_miss:  state_n = refill_v_i ? e_ready : e_miss;
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_ready;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (miss_v_o)
    begin
      miss_addr_r  <= tv_block_addr;
      miss_way_v_r <= tv_i.way_v;
    end
  end

  // Request level rises together with the miss strobe
  assign miss_req_v_o    = (state_r == e_miss) | miss_v_o;
  assign miss_req_addr_o = miss_v_o ? tv_block_addr : miss_addr_r;

  ////////////////////////////////////////////////////////////
  // Victim choice and refill write
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    victim_oh     = '0;
    invalid_found = 1'b0;
    for (int w = 0; w < icache_pkg::ways_c; w++)
    begin
      if (!miss_way_v_r[w] && !invalid_found)
      begin
        victim_oh[w]  = 1'b1;
        invalid_found = 1'b1;
      end
    end
    // LRU way when both ways are valid
    if (!invalid_found)
      victim_oh[lru_r[miss_index]] = 1'b1;
  end

  assign wr_o = '{v: (state_r == e_miss) & refill_v_i,
                  index: miss_index,
                  way: victim_oh,
                  entry: '{v: 1'b1,
                           tag: miss_addr_r[icache_pkg::addr_width_c-1 -:
                                            icache_pkg::ptag_width_c]},
                  block: refill_block_i};

  // LRU bit names the way to evict next
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      lru_r <= '0;
    else if (data_v_o)
      lru_r[tv_index] <= ~hit_id;
    else if (wr_o.v)
      lru_r[miss_index] <= ~victim_oh[1];
  end

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
`default_nettype none

module icache_top
  #(parameter int sets_p = icache_pkg::sets_c
    )
  (input wire                                     clk_i
   , input wire                                   reset_i

   // Fetch request
   , input wire                                   fetch_v_i
   , input wire icache_pkg::fetch_req_s           fetch_req_i
   , output logic                                 ready_o

   // Physical tag, one cycle after acceptance
   , input wire                                   ptag_v_i
   , input wire [icache_pkg::ptag_width_c-1:0]    ptag_i

   // Results
   , output logic [icache_pkg::instr_width_c-1:0] data_o
   , output logic                                 data_v_o
   , output logic                                 miss_v_o

   // Refill
   , output logic                                 miss_req_v_o
   , output logic [icache_pkg::addr_width_c-1:0]  miss_req_addr_o
   , input wire                                   refill_v_i
   , input wire icache_pkg::block_t               refill_block_i
   );

  icache_pkg::array_rd_s                           rd;
  icache_pkg::array_wr_s                           wr;
  icache_pkg::tag_entry_s [icache_pkg::ways_c-1:0] tags;
  icache_pkg::block_t [icache_pkg::ways_c-1:0]     blocks;
  icache_pkg::tv_stage_s                           tv;
  logic                                            accept_ok;
  logic                                            miss_now;

  icache_tag_lookup lookup
    (.clk_i        (clk_i)
     ,.reset_i     (reset_i)
     ,.fetch_v_i   (fetch_v_i)
     ,.fetch_req_i (fetch_req_i)
     ,.ready_o     (ready_o)
     ,.rd_o        (rd)
     ,.ptag_v_i    (ptag_v_i)
     ,.ptag_i      (ptag_i)
     ,.tags_i      (tags)
     ,.blocks_i    (blocks)
     ,.accept_ok_i (accept_ok)
     ,.miss_now_i  (miss_now)
     ,.tv_o        (tv)
     );

  icache_arrays #(.sets_p(sets_p)) arrays
    (.clk_i    (clk_i)
     ,.reset_i (reset_i)
     ,.rd_i    (rd)
     ,.wr_i    (wr)
     ,.tags_o  (tags)
     ,.blocks_o(blocks)
     );

  icache_tag_verify #(.sets_p(sets_p)) verify
    (.clk_i           (clk_i)
     ,.reset_i        (reset_i)
     ,.tv_i           (tv)
     ,.refill_v_i     (refill_v_i)
     ,.refill_block_i (refill_block_i)
     ,.wr_o           (wr)
     ,.accept_ok_o    (accept_ok)
     ,.miss_now_o     (miss_now)
     ,.data_o         (data_o)
     ,.data_v_o       (data_v_o)
     ,.miss_v_o       (miss_v_o)
     ,.miss_req_v_o   (miss_req_v_o)
     ,.miss_req_addr_o(miss_req_addr_o)
     );

endmodule

`default_nettype wire

// ==== filelist.f ====
design/icache_pkg.sv
design/icache_sram.sv
design/icache_arrays.sv
design/icache_tag_lookup.sv
design/icache_tag_verify.sv
design/icache_top.sv
bench/icache_assertions.sv
bench/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the icache testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert --top-module icache_tb -f filelist.f -o icache_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/icache_sim > sim.log 2>&1
cat sim.log

grep -q "Everything OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
